// File: common/branch_params.svh
`ifndef BRANCH_PARAMS_SVH
`define BRANCH_PARAMS_SVH

// Datapath width for operands, pc and targets
// The slice also builds at 64 for RV64
`define BRU_XLEN 32

// Reorder buffer tag width
`define BRU_TAG_W 5

// Link address step from pc
// Always 4 since compressed instructions are not handled
`define BRU_LINK_STEP 4

`endif

// File: common/branch_pkg.sv
package branch_pkg;

    // Major opcode field, instr[6:2]
    localparam logic [4:0] OPC_BRANCH = 5'b11000;
    localparam logic [4:0] OPC_JALR   = 5'b11001;
    localparam logic [4:0] OPC_JAL    = 5'b11011;
    localparam logic [4:0] OPC_AUIPC  = 5'b00101;

    // Operation class carried down the pipeline
    typedef enum logic [2:0] {
        BR_NONE  = 3'd0,
        BR_COND  = 3'd1,
        BR_JAL   = 3'd2,
        BR_JALR  = 3'd3,
        BR_AUIPC = 3'd4
    } branch_op_t;

    // Condition code, same encoding as funct3
    // 010 and 011 are reserved in the ISA and never take
    typedef enum logic [2:0] {
        COND_EQ    = 3'b000,
        COND_NE    = 3'b001,
        COND_NEVER = 3'b010,
        COND_LT    = 3'b100,
        COND_GE    = 3'b101,
        COND_LTU   = 3'b110,
        COND_GEU   = 3'b111
    } branch_cond_t;

    // Operations that the predictor tracks
    function automatic logic is_ctrl_xfer(branch_op_t op);
        return (op == BR_COND) || (op == BR_JAL) || (op == BR_JALR);
    endfunction

    // Operations that write a destination register
    function automatic logic writes_rd(branch_op_t op);
        return (op == BR_JAL) || (op == BR_JALR) || (op == BR_AUIPC);
    endfunction

endpackage

// File: logic/branch_decode.sv
`timescale 1ns/10ps

`include "branch_params.svh"

module branch_decode (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       valid_in,
    input  logic [4:0]                 opcode,
    input  logic [2:0]                 funct3,
    input  logic [`BRU_XLEN-1:0]       rs1,
    input  logic [`BRU_XLEN-1:0]       rs2,
    input  logic [`BRU_XLEN-1:0]       pc,
    input  logic [`BRU_XLEN-1:0]       offset,
    input  logic [`BRU_TAG_W-1:0]      rob_tag,
    input  logic                       pred_taken,
    input  logic [`BRU_XLEN-1:0]       pred_target,
    output logic                       d_valid,
    output branch_pkg::branch_op_t     d_op,
    output branch_pkg::branch_cond_t   d_cond,
    output logic [`BRU_XLEN-1:0]       d_rs1,
    output logic [`BRU_XLEN-1:0]       d_rs2,
    output logic [`BRU_XLEN-1:0]       d_pc,
    output logic [`BRU_XLEN-1:0]       d_offset,
    output logic [`BRU_TAG_W-1:0]      d_tag,
    output logic                       d_pred_taken,
    output logic [`BRU_XLEN-1:0]       d_pred_target
);

    import branch_pkg::*;

    branch_op_t   op_c;
    branch_cond_t cond_c;

    // Opcode classification, the only place the opcode is looked at
    always_comb begin
        case (opcode)
            OPC_BRANCH: op_c = BR_COND;
            OPC_JAL:    op_c = BR_JAL;
            OPC_JALR:   op_c = BR_JALR;
            OPC_AUIPC:  op_c = BR_AUIPC;
            default:    op_c = BR_NONE;   // Not ours, flows through silently
        endcase
    end

    // funct3 to condition
    always_comb begin
        case (funct3)
            3'b000:  cond_c = COND_EQ;
            3'b001:  cond_c = COND_NE;
            3'b100:  cond_c = COND_LT;
            3'b101:  cond_c = COND_GE;
            3'b110:  cond_c = COND_LTU;
            3'b111:  cond_c = COND_GEU;
            default: cond_c = COND_NEVER;  // Reserved encodings
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            d_valid <= 1'b0;
        end else begin
            d_valid <= valid_in;
        end
    end

    // Stage 1 payload
    always_ff @(posedge clk) begin
        d_op          <= op_c;
        d_cond        <= cond_c;
        d_rs1         <= rs1;
        d_rs2         <= rs2;
        d_pc          <= pc;
        d_offset      <= offset;
        d_tag         <= rob_tag;
        d_pred_taken  <= pred_taken;
        d_pred_target <= pred_target;
    end

endmodule

// File: branch_fu/branch_fu.sv
`timescale 1ns/10ps

`include "branch_params.svh"

module branch_fu (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       d_valid,
    input  branch_pkg::branch_op_t     d_op,
    input  branch_pkg::branch_cond_t   d_cond,
    input  logic [`BRU_XLEN-1:0]       d_rs1,
    input  logic [`BRU_XLEN-1:0]       d_rs2,
    input  logic [`BRU_XLEN-1:0]       d_pc,
    input  logic [`BRU_XLEN-1:0]       d_offset,
    input  logic [`BRU_TAG_W-1:0]      d_tag,
    input  logic                       d_pred_taken,
    input  logic [`BRU_XLEN-1:0]       d_pred_target,
    output logic                       f_valid,
    output branch_pkg::branch_op_t     f_op,
    output logic                       f_taken,
    output logic [`BRU_XLEN-1:0]       f_target,
    output logic [`BRU_XLEN-1:0]       f_link_data,
    output logic [`BRU_XLEN-1:0]       f_pc,
    output logic [`BRU_TAG_W-1:0]      f_tag,
    output logic                       f_pred_taken,
    output logic [`BRU_XLEN-1:0]       f_pred_target
);

    import branch_pkg::*;

    localparam logic [`BRU_XLEN-1:0] LINK_STEP = `BRU_LINK_STEP;

    logic                 eq;
    logic                 lt_s;
    logic                 lt_u;
    logic                 cond_hit;
    logic                 taken_c;
    logic [`BRU_XLEN-1:0] base;
    logic [`BRU_XLEN-1:0] sum;
    logic [`BRU_XLEN-1:0] target_c;
    logic [`BRU_XLEN-1:0] link_c;

    // Comparators shared by all six conditions
    assign eq   = (d_rs1 == d_rs2);
    assign lt_s = ($signed(d_rs1) < $signed(d_rs2));
    assign lt_u = (d_rs1 < d_rs2);

    always_comb begin
        case (d_cond)
            COND_EQ:  cond_hit = eq;
            COND_NE:  cond_hit = !eq;
            COND_LT:  cond_hit = lt_s;
            COND_GE:  cond_hit = !lt_s;   // Includes equal
            COND_LTU: cond_hit = lt_u;
            COND_GEU: cond_hit = !lt_u;
            default:  cond_hit = 1'b0;
        endcase
    end

    always_comb begin
        case (d_op)
            BR_COND:        taken_c = cond_hit;
            BR_JAL, BR_JALR: taken_c = 1'b1;
            default:        taken_c = 1'b0;   // AUIPC never counts as taken
        endcase
    end

    // One adder covers branch, JAL, JALR and AUIPC
    assign base = (d_op == BR_JALR) ? d_rs1 : d_pc;
    assign sum  = $unsigned($signed(base) + $signed(d_offset));

    // JALR drops bit 0 of the target
    assign target_c = {sum[`BRU_XLEN-1:1], sum[0] & (d_op != BR_JALR)};

    // AUIPC result, else pc+4 which is also the fall-through address
    assign link_c = (d_op == BR_AUIPC) ? sum : d_pc + LINK_STEP;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            f_valid <= 1'b0;
        end else begin
            f_valid <= d_valid;
        end
    end

    always_ff @(posedge clk) begin
        f_op          <= d_op;
        f_taken       <= taken_c;
        f_target      <= target_c;
        f_link_data   <= link_c;
        f_pc          <= d_pc;
        f_tag         <= d_tag;
        f_pred_taken  <= d_pred_taken;
        f_pred_target <= d_pred_target;
    end

endmodule

// File: logic/branch_resolve.sv
`timescale 1ns/10ps

`include "branch_params.svh"

module branch_resolve (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       f_valid,
    input  branch_pkg::branch_op_t     f_op,
    input  logic                       f_taken,
    input  logic [`BRU_XLEN-1:0]       f_target,
    input  logic [`BRU_XLEN-1:0]       f_link_data,
    input  logic [`BRU_XLEN-1:0]       f_pc,
    input  logic [`BRU_TAG_W-1:0]      f_tag,
    input  logic                       f_pred_taken,
    input  logic [`BRU_XLEN-1:0]       f_pred_target,
    output logic                       wb_valid,
    output logic [`BRU_TAG_W-1:0]      wb_tag,
    output logic [`BRU_XLEN-1:0]       wb_data,
    output logic                       upd_valid,
    output logic                       upd_taken,
    output logic [`BRU_XLEN-1:0]       upd_pc,
    output logic [`BRU_XLEN-1:0]       upd_target,
    output logic                       redirect,
    output logic [`BRU_XLEN-1:0]       redirect_pc
);

    import branch_pkg::*;

    logic                 ctrl_c;
    logic                 wr_c;
    logic                 dir_miss;
    logic                 tgt_miss;
    logic                 mispredict;
    logic [`BRU_XLEN-1:0] fix_pc;

    assign ctrl_c = f_valid && is_ctrl_xfer(f_op);
    assign wr_c   = f_valid && writes_rd(f_op);

    // Direction wrong, or taken to somewhere else than predicted
    assign dir_miss   = (f_taken != f_pred_taken);
    assign tgt_miss   = f_taken && (f_target != f_pred_target);
    assign mispredict = ctrl_c && (dir_miss || tgt_miss);

    // f_link_data holds pc+4 for every control transfer
    assign fix_pc = f_taken ? f_target : f_link_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid  <= 1'b0;
            upd_valid <= 1'b0;
            redirect  <= 1'b0;
        end else begin
            wb_valid  <= wr_c;
            upd_valid <= ctrl_c;
            redirect  <= mispredict;    // One cycle per mispredicted op
        end
    end

    // Writeback group
    always_ff @(posedge clk) begin
        wb_tag  <= f_tag;
        wb_data <= f_link_data;
    end

    // Predictor update group
    always_ff @(posedge clk) begin
        upd_taken  <= f_taken;
        upd_pc     <= f_pc;
        upd_target <= f_target;
    end

    // Fetch restart address
    always_ff @(posedge clk) begin
        redirect_pc <= fix_pc;
    end

endmodule

// File: logic/branch_unit_top.sv
`timescale 1ns/10ps

`include "branch_params.svh"

module branch_unit_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  valid_in,
    input  logic [4:0]            opcode,
    input  logic [2:0]            funct3,
    input  logic [`BRU_XLEN-1:0]  rs1,
    input  logic [`BRU_XLEN-1:0]  rs2,
    input  logic [`BRU_XLEN-1:0]  pc,
    input  logic [`BRU_XLEN-1:0]  offset,
    input  logic [`BRU_TAG_W-1:0] rob_tag,
    input  logic                  pred_taken,
    input  logic [`BRU_XLEN-1:0]  pred_target,
    output logic                  wb_valid,
    output logic [`BRU_TAG_W-1:0] wb_tag,
    output logic [`BRU_XLEN-1:0]  wb_data,
    output logic                  upd_valid,
    output logic                  upd_taken,
    output logic [`BRU_XLEN-1:0]  upd_pc,
    output logic [`BRU_XLEN-1:0]  upd_target,
    output logic                  redirect,
    output logic [`BRU_XLEN-1:0]  redirect_pc
);

    import branch_pkg::*;

    // Decode to execute
    logic                  d_valid;
    branch_op_t            d_op;
    branch_cond_t          d_cond;
    logic [`BRU_XLEN-1:0]  d_rs1;
    logic [`BRU_XLEN-1:0]  d_rs2;
    logic [`BRU_XLEN-1:0]  d_pc;
    logic [`BRU_XLEN-1:0]  d_offset;
    logic [`BRU_TAG_W-1:0] d_tag;
    logic                  d_pred_taken;
    logic [`BRU_XLEN-1:0]  d_pred_target;

    // Execute to resolve
    logic                  f_valid;
    branch_op_t            f_op;
    logic                  f_taken;
    logic [`BRU_XLEN-1:0]  f_target;
    logic [`BRU_XLEN-1:0]  f_link_data;
    logic [`BRU_XLEN-1:0]  f_pc;
    logic [`BRU_TAG_W-1:0] f_tag;
    logic                  f_pred_taken;
    logic [`BRU_XLEN-1:0]  f_pred_target;

    branch_decode branch_decode_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .valid_in      (valid_in),
        .opcode        (opcode),
        .funct3        (funct3),
        .rs1           (rs1),
        .rs2           (rs2),
        .pc            (pc),
        .offset        (offset),
        .rob_tag       (rob_tag),
        .pred_taken    (pred_taken),
        .pred_target   (pred_target),
        .d_valid       (d_valid),
        .d_op          (d_op),
        .d_cond        (d_cond),
        .d_rs1         (d_rs1),
        .d_rs2         (d_rs2),
        .d_pc          (d_pc),
        .d_offset      (d_offset),
        .d_tag         (d_tag),
        .d_pred_taken  (d_pred_taken),
        .d_pred_target (d_pred_target)
    );

    branch_fu branch_fu_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .d_valid       (d_valid),
        .d_op          (d_op),
        .d_cond        (d_cond),
        .d_rs1         (d_rs1),
        .d_rs2         (d_rs2),
        .d_pc          (d_pc),
        .d_offset      (d_offset),
        .d_tag         (d_tag),
        .d_pred_taken  (d_pred_taken),
        .d_pred_target (d_pred_target),
        .f_valid       (f_valid),
        .f_op          (f_op),
        .f_taken       (f_taken),
        .f_target      (f_target),
        .f_link_data   (f_link_data),
        .f_pc          (f_pc),
        .f_tag         (f_tag),
        .f_pred_taken  (f_pred_taken),
        .f_pred_target (f_pred_target)
    );

    branch_resolve branch_resolve_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .f_valid       (f_valid),
        .f_op          (f_op),
        .f_taken       (f_taken),
        .f_target      (f_target),
        .f_link_data   (f_link_data),
        .f_pc          (f_pc),
        .f_tag         (f_tag),
        .f_pred_taken  (f_pred_taken),
        .f_pred_target (f_pred_target),
        .wb_valid      (wb_valid),
        .wb_tag        (wb_tag),
        .wb_data       (wb_data),
        .upd_valid     (upd_valid),
        .upd_taken     (upd_taken),
        .upd_pc        (upd_pc),
        .upd_target    (upd_target),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc)
    );

endmodule

// File: tb/branch_unit_props.sv
`timescale 1ns/10ps

module branch_unit_props (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   f_valid,
    input branch_pkg::branch_op_t f_op,
    input logic                   wb_valid,
    input logic                   upd_valid,
    input logic                   redirect
);

    import branch_pkg::*;

    int reset_fails = 0;
    int redirect_fails = 0;
    int overlap_fails = 0;
    int fail_count;

    assign fail_count = reset_fails + redirect_fails + overlap_fails;

    // Output valid bits stay clear while reset is held
    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> (!wb_valid && !upd_valid && !redirect))
        else begin
            reset_fails++;
            $error("output strobe high during reset");
        end

    redirect_has_update: assert property (@(posedge clk) disable iff (!rst_n)
        redirect |-> upd_valid)
        else begin
            redirect_fails++;
            $error("redirect without upd_valid");
        end

    // A conditional branch never writes a register
    cond_no_writeback: assert property (@(posedge clk) disable iff (!rst_n)
        (f_valid && f_op == BR_COND) |=> !(wb_valid && upd_valid))
        else begin
            overlap_fails++;
            $error("wb_valid and upd_valid together for a conditional branch");
        end

endmodule

// File: tb/branch_unit_checker.sv
`timescale 1ns/10ps

`include "branch_params.svh"

module branch_unit_checker (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  valid_in,
    input  logic [4:0]            opcode,
    input  logic [2:0]            funct3,
    input  logic [`BRU_XLEN-1:0]  rs1,
    input  logic [`BRU_XLEN-1:0]  rs2,
    input  logic [`BRU_XLEN-1:0]  pc,
    input  logic [`BRU_XLEN-1:0]  offset,
    input  logic [`BRU_TAG_W-1:0] rob_tag,
    input  logic                  pred_taken,
    input  logic [`BRU_XLEN-1:0]  pred_target,
    input  logic                  wb_valid,
    input  logic [`BRU_TAG_W-1:0] wb_tag,
    input  logic [`BRU_XLEN-1:0]  wb_data,
    input  logic                  upd_valid,
    input  logic                  upd_taken,
    input  logic [`BRU_XLEN-1:0]  upd_pc,
    input  logic [`BRU_XLEN-1:0]  upd_target,
    input  logic                  redirect,
    input  logic [`BRU_XLEN-1:0]  redirect_pc,
    output int                    value_errs,
    output int                    strobe_errs,
    output int                    ops_seen,
    output int                    pending
);

    import branch_pkg::*;

    typedef struct packed {
        logic [31:0]           due;
        logic                  wr;
        logic                  ctrl;
        logic                  redir;
        logic                  taken;
        logic [`BRU_TAG_W-1:0] tag;
        logic [`BRU_XLEN-1:0]  wb_data;
        logic [`BRU_XLEN-1:0]  pc;
        logic [`BRU_XLEN-1:0]  target;
        logic [`BRU_XLEN-1:0]  redir_pc;
    } exp_t;

    exp_t        exp_q[$];
    logic [31:0] cyc = '0;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Expected result of the operation presented on the inputs right now
    function automatic exp_t predict();
        exp_t                 e;
        logic                 is_cond;
        logic                 is_jalr;
        logic [`BRU_XLEN-1:0] sum;
        is_cond = (opcode == OPC_BRANCH);
        is_jalr = (opcode == OPC_JALR);
        e.due   = cyc + 3;    // Three register stages, out three cycles on
        e.tag   = rob_tag;
        e.pc    = pc;
        e.wr    = (opcode == OPC_JAL) || is_jalr || (opcode == OPC_AUIPC);
        e.ctrl  = is_cond || (opcode == OPC_JAL) || is_jalr;
        e.taken = 1'b0;
        if (is_cond) begin
            case (funct3)
                3'b000:  e.taken = (rs1 == rs2);
                3'b001:  e.taken = (rs1 != rs2);
                3'b100:  e.taken = ($signed(rs1) < $signed(rs2));
                3'b101:  e.taken = ($signed(rs1) >= $signed(rs2));
                3'b110:  e.taken = (rs1 < rs2);
                3'b111:  e.taken = (rs1 >= rs2);
                default: e.taken = 1'b0;
            endcase
        end else if (e.ctrl) begin
            e.taken = 1'b1;
        end
        sum       = is_jalr ? rs1 + offset : pc + offset;
        e.target  = is_jalr ? {sum[`BRU_XLEN-1:1], 1'b0} : sum;
        e.wb_data = (opcode == OPC_AUIPC) ? sum : pc + `BRU_LINK_STEP;
        e.redir   = e.ctrl && ((e.taken != pred_taken) ||
                               (e.taken && (e.target != pred_target)));
        e.redir_pc = e.taken ? e.target : pc + `BRU_LINK_STEP;
        return e;
    endfunction

    task automatic check_val(input string name, input logic [`BRU_XLEN-1:0] exp_v,
                             input logic [`BRU_XLEN-1:0] got);
        if (got !== exp_v) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp_v, got);
            value_errs++;
        end
    endtask

    task automatic check_strobe(input string name, input logic exp_v, input logic got);
        if (got !== exp_v) begin
            $display("** Error at %0t: %s expected %b, got %b", $time, name, exp_v, got);
            strobe_errs++;
        end
    endtask

    task automatic compare_out(input exp_t e);
        check_strobe("wb_valid", e.wr, wb_valid);
        check_strobe("upd_valid", e.ctrl, upd_valid);
        check_strobe("redirect", e.redir, redirect);
        if (e.wr && wb_valid) begin
            check_val("wb_tag", {{(`BRU_XLEN-`BRU_TAG_W){1'b0}}, e.tag},
                      {{(`BRU_XLEN-`BRU_TAG_W){1'b0}}, wb_tag});
            check_val("wb_data", e.wb_data, wb_data);
        end
        if (e.ctrl && upd_valid) begin
            check_val("upd_taken", {{(`BRU_XLEN-1){1'b0}}, e.taken},
                      {{(`BRU_XLEN-1){1'b0}}, upd_taken});
            check_val("upd_pc", e.pc, upd_pc);
            check_val("upd_target", e.target, upd_target);
        end
        if (e.redir && redirect) begin
            check_val("redirect_pc", e.redir_pc, redirect_pc);
        end
    endtask

    // Mid-cycle, where inputs and outputs are both settled
    always @(negedge clk) begin
        if (!rst_n) begin
            exp_q.delete();
            value_errs  = 0;
            strobe_errs = 0;
            ops_seen    = 0;
        end else begin
            if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
                compare_out(exp_q.pop_front());
            end else begin
                check_strobe("wb_valid", 1'b0, wb_valid);   // Nothing due
                check_strobe("upd_valid", 1'b0, upd_valid);
                check_strobe("redirect", 1'b0, redirect);
            end
            if (valid_in) begin
                exp_q.push_back(predict());
                ops_seen++;
            end
        end
        pending = exp_q.size();
    end

endmodule

// File: tb/branch_unit_tb.sv
`timescale 1ns/10ps

`include "branch_params.svh"

module branch_unit_tb;

    import branch_pkg::*;

    // One row of the stimulus table
    typedef struct packed {
        logic [4:0]           opcode;
        logic [2:0]           funct3;
        logic [`BRU_XLEN-1:0] rs1;
        logic [`BRU_XLEN-1:0] rs2;
        logic [`BRU_XLEN-1:0] pc;
        logic [`BRU_XLEN-1:0] offset;
        logic                 pred_taken;
        logic [`BRU_XLEN-1:0] pred_target;
    } stim_t;

    logic                  clk;
    logic                  rst_n;
    logic                  valid_in;
    logic [4:0]            opcode;
    logic [2:0]            funct3;
    logic [`BRU_XLEN-1:0]  rs1;
    logic [`BRU_XLEN-1:0]  rs2;
    logic [`BRU_XLEN-1:0]  pc;
    logic [`BRU_XLEN-1:0]  offset;
    logic [`BRU_TAG_W-1:0] rob_tag;
    logic                  pred_taken;
    logic [`BRU_XLEN-1:0]  pred_target;
    logic                  wb_valid;
    logic [`BRU_TAG_W-1:0] wb_tag;
    logic [`BRU_XLEN-1:0]  wb_data;
    logic                  upd_valid;
    logic                  upd_taken;
    logic [`BRU_XLEN-1:0]  upd_pc;
    logic [`BRU_XLEN-1:0]  upd_target;
    logic                  redirect;
    logic [`BRU_XLEN-1:0]  redirect_pc;

    int     value_errs;
    int     strobe_errs;
    int     ops_seen;
    int     pending;
    int     prop_fails;
    int     wait_cycles;
    logic   timed_out;
    integer seed;
    stim_t  stim_q[$];

    always #2 clk = ~clk;    // 4 ns period

    branch_unit_top branch_unit_top_i (.*);

    branch_unit_checker branch_unit_checker_i (.*);

    bind branch_resolve branch_unit_props branch_unit_props_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .f_valid   (f_valid),
        .f_op      (f_op),
        .wb_valid  (wb_valid),
        .upd_valid (upd_valid),
        .redirect  (redirect)
    );

    task automatic add_stim(input logic [4:0] opc, input logic [2:0] f3,
                            input logic [`BRU_XLEN-1:0] a, input logic [`BRU_XLEN-1:0] b,
                            input logic [`BRU_XLEN-1:0] pcv, input logic [`BRU_XLEN-1:0] off,
                            input logic pt, input logic [`BRU_XLEN-1:0] ptgt);
        stim_q.push_back('{opc, f3, a, b, pcv, off, pt, ptgt});
    endtask

    task automatic build_table();
        logic [`BRU_XLEN-1:0] pair_a [3];
        logic [`BRU_XLEN-1:0] pair_b [3];
        logic [31:0]          r;
        logic [`BRU_XLEN-1:0] ra;
        logic [`BRU_XLEN-1:0] rb;
        int                   f;
        int                   p;
        // Equal, signed negative, unsigned large
        pair_a = '{32'h0000_0005, 32'hffff_fffd, 32'hf000_0000};
        pair_b = '{32'h0000_0005, 32'h0000_0007, 32'h0000_0010};
        // All eight funct3 codes, reserved ones included, predicted not taken
        for (f = 0; f < 8; f++) begin
            for (p = 0; p < 3; p++) begin
                add_stim(OPC_BRANCH, 3'(f), pair_a[p], pair_b[p],
                         32'h1000 + 32'(f * 16 + p * 4), 32'h80, 1'b0, 32'h0);
            end
        end
        add_stim(OPC_JAL,    3'b000, 0, 0, 32'h2000, 32'h0000_0100, 1'b1, 32'h2100);
        add_stim(OPC_JAL,    3'b000, 0, 0, 32'h2004, 32'hffff_fff0, 1'b1, 32'h2000); // Bad target
        add_stim(OPC_JALR,   3'b000, 32'h3001, 0, 32'h2008, 32'h10, 1'b1, 32'h3010);
        add_stim(OPC_JALR,   3'b000, 32'h3003, 0, 32'h200c, 32'hffff_fffe, 1'b0, 0);
        add_stim(OPC_AUIPC,  3'b000, 0, 0, 32'h4000, 32'h1234_5000, 1'b1, 32'h4000);
        add_stim(OPC_BRANCH, 3'b000, 7, 7, 32'h5000, 32'h40, 1'b1, 32'h5040);   // Correct
        add_stim(OPC_BRANCH, 3'b000, 7, 7, 32'h5004, 32'h40, 1'b1, 32'h6000);   // Bad target
        add_stim(OPC_BRANCH, 3'b001, 7, 7, 32'h5008, 32'h40, 1'b1, 32'h5048);   // Back to pc+4
        add_stim(OPC_BRANCH, 3'b011, 7, 7, 32'h500c, 32'h40, 1'b1, 32'h504c);
        add_stim(5'b01100,   3'b000, 1, 2, 32'h6000, 32'h4, 1'b1, 32'h0);       // Plain ALU op
        // Random operands and predictions
        for (f = 0; f < 12; f++) begin
            r  = $random(seed);
            ra = $random(seed);
            rb = $random(seed);
            add_stim(OPC_BRANCH, r[2:0], ra, rb, 32'h7000 + 32'(f * 4), 32'h20,
                     r[3], 32'h7020 + 32'(f * 4));
        end
    endtask

    // One entry per cycle, an idle cycle after every fifth
    task automatic apply_stim();
        stim_t s;
        int    i;
        for (i = 0; i < stim_q.size(); i++) begin
            s = stim_q[i];
            @(posedge clk);
            #1;
            valid_in    = 1'b1;
            opcode      = s.opcode;
            funct3      = s.funct3;
            rs1         = s.rs1;
            rs2         = s.rs2;
            pc          = s.pc;
            offset      = s.offset;
            pred_taken  = s.pred_taken;
            pred_target = s.pred_target;
            rob_tag     = rob_tag + 1'b1;
            if (i % 5 == 4) begin
                @(posedge clk);
                #1;
                valid_in = 1'b0;
            end
        end
        @(posedge clk);
        #1;
        valid_in = 1'b0;
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b1;
        valid_in    = 1'b0;
        opcode      = 5'b0;
        funct3      = 3'b0;
        rs1         = '0;
        rs2         = '0;
        pc          = '0;
        offset      = '0;
        rob_tag     = '0;
        pred_taken  = 1'b0;
        pred_target = '0;
        timed_out   = 1'b0;
        seed        = 32'h36d9d965;
        build_table();
        #1 rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;
        apply_stim();
        wait_cycles = 0;
        while (pending != 0 && wait_cycles < 40) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (pending != 0) begin
            timed_out = 1'b1;
            $display("Timeout: pipeline did not drain, %0d operations still pending", pending);
        end
        repeat (4) @(posedge clk);    // Watch for stray strobes
        prop_fails = branch_unit_top_i.branch_resolve_i.branch_unit_props_i.fail_count;
        $display("Checked %0d ops: %0d value errors, %0d strobe errors, %0d assertion failures",
                 ops_seen, value_errs, strobe_errs, prop_fails);
        if (value_errs == 0 && strobe_errs == 0 && prop_fails == 0 && !timed_out) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+common
common/branch_pkg.sv
logic/branch_decode.sv
branch_fu/branch_fu.sv
logic/branch_resolve.sv
logic/branch_unit_top.sv
tb/branch_unit_props.sv
tb/branch_unit_checker.sv
tb/branch_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := branch_unit_tb
FILELIST  := files.f
VFLAGS    := --binary --timing --assert -j 0
RUNFLAGS  := +verilator+error+limit+100
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUNFLAGS) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
